/* bpu_pkg.sv */
`default_nettype none

package bpu_pkg;

    localparam int XLEN     = 32;
    localparam int HIST_W   = 16;
    localparam int N_TAGGED = 2;   // table 1 sees the longer history
    localparam int TT_IDX_W = 8;
    localparam int TT_TAG_W = 10;
    localparam int BM_IDX_W = 9;   // pc[9:1]

    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_STRONG_NT = 2'b00;
    localparam ctr_t CTR_WEAK_NT   = 2'b01;
    localparam ctr_t CTR_WEAK_T    = 2'b10;
    localparam ctr_t CTR_STRONG_T  = 2'b11;

    typedef enum logic [1:0] {
        PROV_BIMODAL = 2'd0,
        PROV_T0      = 2'd1,
        PROV_T1      = 2'd2
    } provider_e;

    typedef enum logic [1:0] {
        CLS_OTHER,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR
    } inst_class_e;

    typedef enum logic [1:0] {
        TT_NONE,
        TT_TRAIN,  // step toward outcome
        TT_RESET,  // strong toward outcome
        TT_ALLOC   // new tag, weak toward outcome
    } tt_cmd_e;

    typedef struct packed {
        logic [TT_IDX_W-1:0] pred_idx;
        logic [TT_TAG_W-1:0] pred_tag;
        logic [TT_IDX_W-1:0] upd_idx;
        logic [TT_TAG_W-1:0] upd_tag;
    } tt_req_t;

    typedef struct packed {
        logic pred_hit;  // partial tag match
        ctr_t ctr;
        logic upd_hit;   // full tag match at update index
    } tt_resp_t;

    typedef struct packed {
        logic              valid;
        logic              taken;
        logic              correct;
        logic [XLEN-1:0]   pc;
        logic [HIST_W-1:0] history;  // history seen at prediction
        logic [XLEN-1:0]   target;
        provider_e         provider;
    } ex_fb_t;

    // one saturating step toward the outcome
    function automatic ctr_t ctr_step(input ctr_t c, input logic taken);
        if (taken) begin
            return (c == CTR_STRONG_T) ? c : c + 2'd1;
        end
        return (c == CTR_STRONG_NT) ? c : c - 2'd1;
    endfunction

endpackage

`default_nettype wire

/* bpu_index_hash.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu_index_hash #(
    parameter int BTB_IDX_W = 8
) (
    input  wire                                          clk,
    input  wire                                          rst,
    input  wire  [bpu_pkg::XLEN-1:0]                     if_pc_i,
    input  bpu_pkg::ex_fb_t                              ex_fb_i,
    output bpu_pkg::tt_req_t [bpu_pkg::N_TAGGED-1:0]     tt_req_o,
    output logic [bpu_pkg::BM_IDX_W-1:0]                 bm_pred_idx_o,
    output logic [bpu_pkg::BM_IDX_W-1:0]                 bm_upd_idx_o,
    output logic [BTB_IDX_W-1:0]                         btb_pred_idx_o,
    output logic [bpu_pkg::XLEN-BTB_IDX_W-3:0]           btb_pred_tag_o,
    output logic [BTB_IDX_W-1:0]                         btb_upd_idx_o,
    output logic [bpu_pkg::XLEN-BTB_IDX_W-3:0]           btb_upd_tag_o,
    output logic [bpu_pkg::HIST_W-1:0]                   history_o
);
    import bpu_pkg::*;

    logic [HIST_W-1:0] ghist;

    function automatic logic [TT_IDX_W-1:0] tt_idx(input logic [XLEN-1:0] pc,
                                                   input logic [HIST_W-1:0] h, input int tbl);
        return pc[7:0] ^ ((tbl == 0) ? h[7:0] : h[15:8]);
    endfunction

    function automatic logic [TT_TAG_W-1:0] tt_tag(input logic [XLEN-1:0] pc,
                                                   input logic [HIST_W-1:0] h, input int tbl);
        return pc[17:8] ^ ((tbl == 0) ? h[15:6] : TT_TAG_W'(h[7:0]));
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
        end else if (ex_fb_i.valid) begin
            ghist <= {ghist[HIST_W-2:0], ex_fb_i.taken};  // resolved outcome in at lsb
        end
    end

    always_comb begin
        for (int t = 0; t < N_TAGGED; t++) begin
            tt_req_o[t].pred_idx = tt_idx(if_pc_i, ghist, t);
            tt_req_o[t].pred_tag = tt_tag(if_pc_i, ghist, t);
            tt_req_o[t].upd_idx  = tt_idx(ex_fb_i.pc, ex_fb_i.history, t);
            tt_req_o[t].upd_tag  = tt_tag(ex_fb_i.pc, ex_fb_i.history, t);
        end
    end

    assign bm_pred_idx_o  = if_pc_i[BM_IDX_W:1];
    assign bm_upd_idx_o   = ex_fb_i.pc[BM_IDX_W:1];
    assign btb_pred_idx_o = if_pc_i[BTB_IDX_W+1:2];
    assign btb_pred_tag_o = if_pc_i[XLEN-1:BTB_IDX_W+2];
    assign btb_upd_idx_o  = ex_fb_i.pc[BTB_IDX_W+1:2];
    assign btb_upd_tag_o  = ex_fb_i.pc[XLEN-1:BTB_IDX_W+2];
    assign history_o      = ghist;

endmodule

`default_nettype wire

/* bpu_tagged_table.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu_tagged_table #(
    parameter int PARTIAL_TAG_W = 6
) (
    input  wire               clk,
    input  wire               rst,
    input  bpu_pkg::tt_req_t  req_i,
    input  bpu_pkg::tt_cmd_e  cmd_i,
    input  wire               taken_i,
    output bpu_pkg::tt_resp_t resp_o
);
    import bpu_pkg::*;

    localparam int DEPTH = 1 << TT_IDX_W;

    logic [TT_TAG_W-1:0] tags [DEPTH];
    ctr_t                ctrs [DEPTH];

    logic [TT_TAG_W-1:0] pred_stored;
    logic [TT_TAG_W-1:0] upd_stored;
    ctr_t                upd_ctr;

    assign pred_stored = tags[req_i.pred_idx];
    assign upd_stored  = tags[req_i.upd_idx];
    assign upd_ctr     = ctrs[req_i.upd_idx];

    // only the upper tag bits take part in the prediction match
    assign resp_o.pred_hit = pred_stored[TT_TAG_W-1 -: PARTIAL_TAG_W] ==
                             req_i.pred_tag[TT_TAG_W-1 -: PARTIAL_TAG_W];
    assign resp_o.ctr      = ctrs[req_i.pred_idx];
    assign resp_o.upd_hit  = (upd_stored == req_i.upd_tag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                tags[i] <= '0;
                ctrs[i] <= CTR_WEAK_NT;
            end
        end else begin
            case (cmd_i)
                TT_TRAIN: begin
                    ctrs[req_i.upd_idx] <= ctr_step(upd_ctr, taken_i);
                end
                TT_RESET: begin
                    ctrs[req_i.upd_idx] <= taken_i ? CTR_STRONG_T : CTR_STRONG_NT;
                end
                TT_ALLOC: begin
                    tags[req_i.upd_idx] <= req_i.upd_tag;
                    ctrs[req_i.upd_idx] <= taken_i ? CTR_WEAK_T : CTR_WEAK_NT;
                end
                default: ;  // TT_NONE
            endcase
        end
    end

endmodule

`default_nettype wire

/* bpu_bimodal.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu_bimodal (
    input  wire                          clk,
    input  wire                          rst,
    input  wire [bpu_pkg::BM_IDX_W-1:0]  pred_idx_i,
    input  wire [bpu_pkg::BM_IDX_W-1:0]  upd_idx_i,
    input  wire                          upd_i,     // feedback valid
    input  wire                          taken_i,
    output logic                         pred_taken_o
);
    import bpu_pkg::*;

    localparam int DEPTH = 1 << BM_IDX_W;  // 512 entries

    ctr_t table_q [DEPTH];

    assign pred_taken_o = table_q[pred_idx_i][1];

    // trained on every resolved control transfer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                table_q[i] <= CTR_WEAK_NT;
            end
        end else if (upd_i) begin
            table_q[upd_idx_i] <= ctr_step(table_q[upd_idx_i], taken_i);
        end
    end

endmodule

`default_nettype wire

/* bpu_btb.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu_btb #(
    parameter int BTB_IDX_W = 8
) (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire  [BTB_IDX_W-1:0]                 pred_idx_i,
    input  wire  [bpu_pkg::XLEN-BTB_IDX_W-3:0]   pred_tag_i,
    input  wire  [BTB_IDX_W-1:0]                 upd_idx_i,
    input  wire  [bpu_pkg::XLEN-BTB_IDX_W-3:0]   upd_tag_i,
    input  wire                                  fill_i,    // valid and taken
    input  wire  [bpu_pkg::XLEN-1:0]             target_i,
    output logic                                 hit_o,
    output logic [bpu_pkg::XLEN-1:0]             target_o
);
    import bpu_pkg::*;

    localparam int DEPTH = 1 << BTB_IDX_W;
    localparam int TAG_W = XLEN - BTB_IDX_W - 2;

    logic             valid_q  [DEPTH];
    logic [TAG_W-1:0] tag_q    [DEPTH];
    logic [XLEN-1:0]  target_q [DEPTH];

    assign hit_o    = valid_q[pred_idx_i] && (tag_q[pred_idx_i] == pred_tag_i);
    assign target_o = target_q[pred_idx_i];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (fill_i) begin
            valid_q[upd_idx_i] <= 1'b1;
        end
    end

    // entry payload qualified by valid_q
    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[upd_idx_i]    <= upd_tag_i;
            target_q[upd_idx_i] <= target_i;  // last taken target wins
        end
    end

endmodule

`default_nettype wire

/* bpu_tage_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu_tage_arbiter (
    input  bpu_pkg::tt_resp_t [bpu_pkg::N_TAGGED-1:0] tt_resp_i,
    input  wire                                       bm_taken_i,
    input  bpu_pkg::ex_fb_t                           ex_fb_i,
    output logic                                      tage_taken_o,
    output bpu_pkg::provider_e                        provider_o,
    output bpu_pkg::tt_cmd_e  [bpu_pkg::N_TAGGED-1:0] tt_cmd_o
);
    import bpu_pkg::*;

    // longest history hit provides with bimodal as fallback
    always_comb begin
        tage_taken_o = bm_taken_i;
        provider_o   = PROV_BIMODAL;
        for (int t = 0; t < N_TAGGED; t++) begin
            if (tt_resp_i[t].pred_hit) begin
                tage_taken_o = tt_resp_i[t].ctr[1];
                provider_o   = provider_e'(t + 1);
            end
        end
    end

    always_comb begin
        logic alloc_done;

        alloc_done = 1'b0;
        for (int t = 0; t < N_TAGGED; t++) begin
            tt_cmd_o[t] = TT_NONE;
        end

        if (ex_fb_i.valid) begin
            if (ex_fb_i.provider != PROV_BIMODAL) begin
                // only the providing table is touched
                for (int t = 0; t < N_TAGGED; t++) begin
                    if (ex_fb_i.provider == provider_e'(t + 1)) begin
                        tt_cmd_o[t] = ex_fb_i.correct ? TT_TRAIN : TT_RESET;
                    end
                end
            end else if (!ex_fb_i.correct) begin
                // bimodal miss claims an entry from the longest history down
                for (int t = N_TAGGED - 1; t >= 0; t--) begin
                    if (!alloc_done && !tt_resp_i[t].upd_hit) begin
                        tt_cmd_o[t] = TT_ALLOC;
                        alloc_done  = 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bpu_next_pc.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu_next_pc (
    input  wire  [bpu_pkg::XLEN-1:0] if_pc_i,
    input  wire  [bpu_pkg::XLEN-1:0] if_inst_i,
    input  wire                      tage_taken_i,
    input  wire                      btb_hit_i,
    input  wire  [bpu_pkg::XLEN-1:0] btb_target_i,
    output logic                     branch_o,
    output logic                     pred_taken_o,
    output logic [bpu_pkg::XLEN-1:0] pred_pc_o
);
    import bpu_pkg::*;

    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    inst_class_e     cls;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_target;

    always_comb begin
        case (if_inst_i[6:0])
            OPC_BRANCH: cls = CLS_BRANCH;
            OPC_JAL:    cls = CLS_JAL;
            OPC_JALR:   cls = CLS_JALR;
            default:    cls = CLS_OTHER;
        endcase
    end

    assign imm_j = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20],
                    if_inst_i[30:21], 1'b0};
    assign imm_b = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25],
                    if_inst_i[11:8], 1'b0};
    assign imm_target = if_pc_i + ((cls == CLS_JAL) ? imm_j : imm_b);

    assign branch_o = (cls != CLS_OTHER);

    always_comb begin
        case (cls)
            CLS_JAL:    pred_taken_o = 1'b1;
            CLS_BRANCH: pred_taken_o = tage_taken_i;
            default:    pred_taken_o = 1'b0;  // jalr target unknown here
        endcase
    end

    always_comb begin
        if (!pred_taken_o) begin
            pred_pc_o = if_pc_i + 32'd4;
        end else if (btb_hit_i) begin
            pred_pc_o = btb_target_i;
        end else begin
            pred_pc_o = imm_target;  // immediate target on a btb miss
        end
    end

endmodule

`default_nettype wire

/* bpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu_top #(
    parameter int BTB_IDX_W     = 8,
    parameter int PARTIAL_TAG_W = 6   // 1..10
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire  [bpu_pkg::XLEN-1:0]   if_pc_i,
    input  wire  [bpu_pkg::XLEN-1:0]   if_inst_i,
    input  bpu_pkg::ex_fb_t            ex_fb_i,
    output logic                       branch_o,
    output logic                       pred_taken_o,
    output logic [bpu_pkg::XLEN-1:0]   pred_pc_o,
    output bpu_pkg::provider_e         provider_o,
    output logic [bpu_pkg::HIST_W-1:0] history_o
);
    import bpu_pkg::*;

    tt_req_t  [N_TAGGED-1:0]      tt_req;
    tt_resp_t [N_TAGGED-1:0]      tt_resp;
    tt_cmd_e  [N_TAGGED-1:0]      tt_cmd;
    logic [BM_IDX_W-1:0]          bm_pred_idx;
    logic [BM_IDX_W-1:0]          bm_upd_idx;
    logic [BTB_IDX_W-1:0]         btb_pred_idx;
    logic [BTB_IDX_W-1:0]         btb_upd_idx;
    logic [XLEN-BTB_IDX_W-3:0]    btb_pred_tag;
    logic [XLEN-BTB_IDX_W-3:0]    btb_upd_tag;
    logic                         bm_taken;
    logic                         tage_taken;
    logic                         btb_hit;
    logic [XLEN-1:0]              btb_target;

    bpu_index_hash #(.BTB_IDX_W(BTB_IDX_W)) u_hash (
        .clk, .rst, .if_pc_i, .ex_fb_i,
        .tt_req_o       (tt_req),
        .bm_pred_idx_o  (bm_pred_idx),
        .bm_upd_idx_o   (bm_upd_idx),
        .btb_pred_idx_o (btb_pred_idx),
        .btb_pred_tag_o (btb_pred_tag),
        .btb_upd_idx_o  (btb_upd_idx),
        .btb_upd_tag_o  (btb_upd_tag),
        .history_o
    );

    for (genvar g = 0; g < N_TAGGED; g++) begin : g_tt
        bpu_tagged_table #(.PARTIAL_TAG_W(PARTIAL_TAG_W)) u_tt (
            .clk, .rst,
            .req_i   (tt_req[g]),
            .cmd_i   (tt_cmd[g]),
            .taken_i (ex_fb_i.taken),
            .resp_o  (tt_resp[g])
        );
    end

    bpu_bimodal u_bimodal (
        .clk, .rst,
        .pred_idx_i   (bm_pred_idx),
        .upd_idx_i    (bm_upd_idx),
        .upd_i        (ex_fb_i.valid),
        .taken_i      (ex_fb_i.taken),
        .pred_taken_o (bm_taken)
    );

    bpu_btb #(.BTB_IDX_W(BTB_IDX_W)) u_btb (
        .clk, .rst,
        .pred_idx_i (btb_pred_idx),
        .pred_tag_i (btb_pred_tag),
        .upd_idx_i  (btb_upd_idx),
        .upd_tag_i  (btb_upd_tag),
        .fill_i     (ex_fb_i.valid & ex_fb_i.taken),
        .target_i   (ex_fb_i.target),
        .hit_o      (btb_hit),
        .target_o   (btb_target)
    );

    bpu_tage_arbiter u_arb (
        .tt_resp_i    (tt_resp),
        .bm_taken_i   (bm_taken),
        .ex_fb_i,
        .tage_taken_o (tage_taken),
        .provider_o,
        .tt_cmd_o     (tt_cmd)
    );

    bpu_next_pc u_next_pc (
        .if_pc_i, .if_inst_i,
        .tage_taken_i (tage_taken),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .branch_o, .pred_taken_o, .pred_pc_o
    );

endmodule

`default_nettype wire

/* bpu_tb_model.svh */
`ifndef BPU_TB_MODEL_SVH
`define BPU_TB_MODEL_SVH

// shadow copy of predictor state stepped once per resolved feedback
logic [HIST_W-1:0]   ref_hist;
ctr_t                ref_bm   [1 << BM_IDX_W];
logic [TT_TAG_W-1:0] ref_tag  [N_TAGGED][1 << TT_IDX_W];
ctr_t                ref_ctr  [N_TAGGED][1 << TT_IDX_W];
logic                ref_bvld [1 << BTB_IDX_W];
logic [XLEN-1:0]     ref_bpc  [1 << BTB_IDX_W];  // whole pc kept and upper bits compared
logic [XLEN-1:0]     ref_btgt [1 << BTB_IDX_W];

function automatic logic [TT_IDX_W-1:0] tagged_index(input logic [XLEN-1:0] pc,
                                                     input logic [HIST_W-1:0] h, input int t);
    return (t == 0) ? (pc[7:0] ^ h[7:0]) : (pc[7:0] ^ h[15:8]);
endfunction

function automatic logic [TT_TAG_W-1:0] tagged_tag(input logic [XLEN-1:0] pc,
                                                   input logic [HIST_W-1:0] h, input int t);
    return (t == 0) ? (pc[17:8] ^ h[15:6]) : (pc[17:8] ^ {2'b00, h[7:0]});
endfunction

function automatic logic partial_match(input logic [TT_TAG_W-1:0] a,
                                       input logic [TT_TAG_W-1:0] b);
    return (a >> (TT_TAG_W - PARTIAL_TAG_W)) == (b >> (TT_TAG_W - PARTIAL_TAG_W));
endfunction

function automatic ctr_t saturate(input ctr_t c, input logic up);
    if (up) begin
        return (c == 2'b11) ? c : c + 2'b01;
    end
    return (c == 2'b00) ? c : c - 2'b01;
endfunction

function automatic logic btb_hit(input logic [XLEN-1:0] pc);
    logic [BTB_IDX_W-1:0] i;
    i = pc[BTB_IDX_W+1:2];
    return ref_bvld[i] && ((ref_bpc[i] >> (BTB_IDX_W + 2)) == (pc >> (BTB_IDX_W + 2)));
endfunction

task automatic reset_model();
    ref_hist = '0;
    foreach (ref_bm[i]) begin
        ref_bm[i] = 2'b01;
    end
    foreach (ref_tag[t, i]) begin
        ref_tag[t][i] = '0;
        ref_ctr[t][i] = 2'b01;
    end
    foreach (ref_bvld[i]) begin
        ref_bvld[i] = 1'b0;
    end
endtask

function automatic pred_t predict(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] inst);
    pred_t               p;
    logic [TT_IDX_W-1:0] i0;
    logic [TT_IDX_W-1:0] i1;
    logic                dir;
    logic [XLEN-1:0]     imm;

    i0         = tagged_index(pc, ref_hist, 0);
    i1         = tagged_index(pc, ref_hist, 1);
    dir        = ref_bm[pc[BM_IDX_W:1]][1];
    p.provider = PROV_BIMODAL;
    // longer history table wins
    if (partial_match(ref_tag[1][i1], tagged_tag(pc, ref_hist, 1))) begin
        dir        = ref_ctr[1][i1][1];
        p.provider = PROV_T1;
    end else if (partial_match(ref_tag[0][i0], tagged_tag(pc, ref_hist, 0))) begin
        dir        = ref_ctr[0][i0][1];
        p.provider = PROV_T0;
    end
    p.branch = (inst[6:0] == 7'b1100011) || (inst[6:0] == 7'b1101111) ||
               (inst[6:0] == 7'b1100111);
    if (inst[6:0] == 7'b1101111) begin
        p.taken = 1'b1;
        imm     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};  // j-type
    end else begin
        p.taken = (inst[6:0] == 7'b1100011) && dir;
        imm     = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};    // b-type
    end
    if (!p.taken) begin
        p.next_pc = pc + 32'd4;
    end else if (btb_hit(pc)) begin
        p.next_pc = ref_btgt[pc[BTB_IDX_W+1:2]];
    end else begin
        p.next_pc = pc + imm;
    end
    return p;
endfunction

task automatic apply_feedback(input ex_fb_t fb);
    logic [TT_IDX_W-1:0] idx [N_TAGGED];
    logic [TT_TAG_W-1:0] tag [N_TAGGED];
    logic                hit [N_TAGGED];
    int                  p;

    if (!fb.valid) begin
        return;
    end
    for (int t = 0; t < N_TAGGED; t++) begin
        idx[t] = tagged_index(fb.pc, fb.history, t);
        tag[t] = tagged_tag(fb.pc, fb.history, t);
        hit[t] = (ref_tag[t][idx[t]] == tag[t]);  // full tag
    end
    if (fb.provider == PROV_T0 || fb.provider == PROV_T1) begin
        p = (fb.provider == PROV_T1) ? 1 : 0;
        ref_ctr[p][idx[p]] = fb.correct ? saturate(ref_ctr[p][idx[p]], fb.taken)
                                        : (fb.taken ? 2'b11 : 2'b00);
    end else if (!fb.correct) begin
        p = !hit[1] ? 1 : (!hit[0] ? 0 : -1);
        if (p >= 0) begin
            ref_tag[p][idx[p]] = tag[p];
            ref_ctr[p][idx[p]] = fb.taken ? 2'b10 : 2'b01;
        end
    end
    ref_bm[fb.pc[BM_IDX_W:1]] = saturate(ref_bm[fb.pc[BM_IDX_W:1]], fb.taken);
    if (fb.taken) begin
        ref_bvld[fb.pc[BTB_IDX_W+1:2]] = 1'b1;
        ref_bpc[fb.pc[BTB_IDX_W+1:2]]  = fb.pc;
        ref_btgt[fb.pc[BTB_IDX_W+1:2]] = fb.target;
    end
    ref_hist = {ref_hist[HIST_W-2:0], fb.taken};
endtask

`endif

/* bpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu_tb;
    import bpu_pkg::*;

    localparam int BTB_IDX_W     = 8;
    localparam int PARTIAL_TAG_W = 6;
    localparam int N_OPS         = 4000;
    localparam int RST_CYCLES    = 3;
    localparam int FB_DELAY      = 3;   // min age of a prediction before it resolves
    localparam int TIMEOUT_NS    = (N_OPS + RST_CYCLES + 4) * 4 * 2;
    localparam logic [31:0] SEED = 32'haebe_47b2;

    typedef struct packed {
        logic            branch;
        logic            taken;
        logic [XLEN-1:0] next_pc;
        provider_e       provider;
    } pred_t;

    // prediction waiting for its ex feedback
    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [HIST_W-1:0] history;
        provider_e         provider;
        logic              pred_taken;
        logic              is_jal;
    } rec_t;

    logic              clk = 1'b0;
    logic              rst;
    logic [XLEN-1:0]   if_pc;
    logic [XLEN-1:0]   if_inst;
    ex_fb_t            ex_fb;
    logic              branch;
    logic              pred_taken;
    logic [XLEN-1:0]   pred_pc;
    provider_e         provider;
    logic [HIST_W-1:0] history;

    logic [XLEN-1:0]   pc_pool [16];
    rec_t              pending [$];
    int                tagged_hits;
    int                btb_hits;

    `include "bpu_tb_model.svh"

    always #2 clk = ~clk;

    bpu_top #(
        .BTB_IDX_W     (BTB_IDX_W),
        .PARTIAL_TAG_W (PARTIAL_TAG_W)
    ) dut (
        .clk, .rst,
        .if_pc_i      (if_pc),
        .if_inst_i    (if_inst),
        .ex_fb_i      (ex_fb),
        .branch_o     (branch),
        .pred_taken_o (pred_taken),
        .pred_pc_o    (pred_pc),
        .provider_o   (provider),
        .history_o    (history)
    );

    task automatic abort_run(input string why);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", why);
    endtask

    task automatic check_pred(input logic [XLEN-1:0] pc, input pred_t got, input pred_t exp);
        if (got !== exp) begin
            $display("MISMATCH branch_o/pred_taken_o/pred_pc_o/provider_o pc %h: got %h exp %h",
                     pc, got, exp);
            abort_run("prediction differs from model");
        end
    endtask

    task automatic check_history(input logic [HIST_W-1:0] got, input logic [HIST_W-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH history_o: got %h exp %h", got, exp);
            abort_run("global history differs from model");
        end
    endtask

    function automatic logic [XLEN-1:0] make_inst(input int cls);
        logic [XLEN-1:0] rnd;
        rnd = $urandom();
        case (cls)
            1:       return {rnd[31:7], 7'b1100011};  // branch
            2:       return {rnd[31:7], 7'b1101111};  // jal
            3:       return {rnd[31:7], 7'b1100111};  // jalr
            default: return {rnd[31:7], 7'b0010011};  // op-imm
        endcase
    endfunction

    // phase 1 fills history with ones, phase 3 with zeros
    function automatic logic outcome(input rec_t r, input int phase);
        case (phase)
            1:       return 1'b1;
            3:       return 1'b0;
            default: return r.is_jal ? 1'b1 : 1'($urandom_range(1, 0));
        endcase
    endfunction

    initial begin
        #(TIMEOUT_NS);
        abort_run("watchdog expired before all operations completed");
    end

    initial begin
        ex_fb_t          fb;
        rec_t            r;
        pred_t           exp;
        pred_t           got;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
        int              cls;
        int              phase;

        void'($urandom(SEED));
        rst         = 1'b1;
        if_pc       = '0;
        if_inst     = '0;
        ex_fb       = '0;
        tagged_hits = 0;
        btb_hits    = 0;
        reset_model();
        for (int i = 0; i < 16; i++) begin
            pc_pool[i] = ($urandom() & 32'h0000_fffc) | 32'h0003_0000;  // tag bits never zero
        end
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int op = 0; op < N_OPS; op++) begin
            phase = op / (N_OPS / 4);
            fb    = '0;
            @(posedge clk);
            if (pending.size() > 6 ||
                (pending.size() >= FB_DELAY && $urandom_range(3, 0) != 0)) begin
                r           = pending.pop_front();
                fb.valid    = 1'b1;
                fb.taken    = outcome(r, phase);
                fb.correct  = (fb.taken == r.pred_taken);
                fb.pc       = r.pc;
                fb.history  = r.history;
                fb.target   = $urandom() & 32'hffff_fffc;
                fb.provider = r.provider;
            end
            cls = (op == 0) ? 0 : $urandom_range(3, 0);
            if (phase == 3 && cls == 2) begin
                cls = 1;
            end
            pc      = pc_pool[$urandom_range(15, 0)];
            inst    = make_inst(cls);
            if_pc   <= pc;
            if_inst <= inst;
            ex_fb   <= fb;

            @(negedge clk);
            exp = predict(pc, inst);
            got = '{branch, pred_taken, pred_pc, provider};
            check_pred(pc, got, exp);
            check_history(history, ref_hist);
            if (exp.branch) begin
                pending.push_back('{pc, ref_hist, exp.provider, exp.taken, cls == 2});
            end
            if (exp.branch && exp.provider != PROV_BIMODAL) begin
                tagged_hits++;
            end
            if (exp.taken && btb_hit(pc)) begin
                btb_hits++;
            end
            apply_feedback(fb);  // takes effect at the next rising edge
        end

        if (tagged_hits == 0 || btb_hits == 0) begin
            $display("tagged provider hits %0d, btb target uses %0d", tagged_hits, btb_hits);
            abort_run("tagged tables or btb never provided a prediction");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
bpu_pkg.sv
bpu_index_hash.sv
bpu_tagged_table.sv
bpu_bimodal.sv
bpu_btb.sv
bpu_tage_arbiter.sv
bpu_next_pc.sv
bpu_top.sv
bpu_tb.sv

/* Bender.yml */
package:
  name: bpu

sources:
  - files:
      - bpu_pkg.sv
      - bpu_index_hash.sv
      - bpu_tagged_table.sv
      - bpu_bimodal.sv
      - bpu_btb.sv
      - bpu_tage_arbiter.sv
      - bpu_next_pc.sv
      - bpu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - bpu_tb.sv
